// ==== hw/ChecksumPkg.sv ====
package ChecksumPkg;

    // host data word width, also half the checksum width
    localparam int WordWidth = 16;

    // one host word as held in the block RAM
    typedef logic [WordWidth-1:0] WordT;

    // second sum in the upper half, first sum in the lower half
    typedef logic [2*WordWidth-1:0] SumT;

    // fletcher modulus, both sums stay in 0 .. 65534
    localparam int unsigned FletcherMod = 65535;

    // scanner sequence
    typedef enum logic [1:0] {
        // waiting for start
        ScanIdle,
        // issuing reads and collecting returned words
        ScanRead,
        // letting the second sum settle
        ScanDrain,
        // result captured, done high
        ScanDone
    } ScanStateT;

endpackage

// ==== hw/FletcherChecksum.sv ====
`timescale 1ns/1ps

module FletcherChecksum (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              en,
    input  ChecksumPkg::WordT din,
    output ChecksumPkg::SumT  dout
);
    import ChecksumPkg::*;

    // word plus one carry bit
    typedef logic [WordWidth:0] WideT;

    localparam WideT Mod = WideT'(FletcherMod);

    // raw running sums, may sit one modulus too high
    WideT aSum;
    WideT bSum;
    // sums after the overflow fold
    WideT aFold;
    WideT bFold;
    // second sum trails the first by one cycle
    logic enPrev;

    // subtract on overflow
    // a single step covers it since both addends are below Mod
    assign aFold = (aSum >= Mod) ? aSum - Mod : aSum;
    assign bFold = (bSum >= Mod) ? bSum - Mod : bSum;

    always_ff @(posedge clk) begin
        if (rst) begin
            aSum   <= '0;
            bSum   <= '0;
            enPrev <= 1'b0;
        end else if (clear) begin
            // new block starts from zero
            aSum   <= '0;
            bSum   <= '0;
            enPrev <= 1'b0;
        end else begin
            enPrev <= en;
            if (en) begin
                aSum <= aFold + {1'b0, din};
            end else begin
                aSum <= aFold;
            end
            // picks up the first sum written on the previous edge
            if (enPrev) begin
                bSum <= bFold + aFold;
            end else begin
                bSum <= bFold;
            end
        end
    end

    assign dout = {bFold[WordWidth-1:0], aFold[WordWidth-1:0]};
endmodule

// ==== hw/BlockRam.sv ====
`timescale 1ns/1ps

module BlockRam #(
    parameter int Depth = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(Depth)-1:0] addr,
    input  ChecksumPkg::WordT        wrData,
    output ChecksumPkg::WordT        rdData
);
    import ChecksumPkg::*;

    // block storage, contents undefined until written
    WordT mem [Depth];

    // single port, write and read share the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wrData;
        end
    end

    // registered read, one cycle latency
    // a write cycle returns the old word, which nobody consumes
    always_ff @(posedge clk) begin
        rdData <= mem[addr];
    end
endmodule

// ==== hw/RamArbiter.sv ====
`timescale 1ns/1ps

module RamArbiter #(
    parameter int Depth = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fillReq,
    input  logic [$clog2(Depth)-1:0] fillAddr,
    input  ChecksumPkg::WordT        fillData,
    input  logic                     scanReq,
    input  logic [$clog2(Depth)-1:0] scanAddr,
    output logic                     scanGrant,
    output logic                     rdValid,
    output logic                     ramWe,
    output logic [$clog2(Depth)-1:0] ramAddr,
    output ChecksumPkg::WordT        ramWrData
);
    // fill always wins the port
    assign ramWe = fillReq;

    // scan only gets the port when fill is quiet
    assign scanGrant = scanReq && !fillReq;

    // address mux, owner of the port drives it
    assign ramAddr = fillReq ? fillAddr : scanAddr;

    // write data only meaningful during a fill write
    assign ramWrData = fillReq ? fillData : '0;

    // granted read comes back one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= scanGrant;
        end
    end
endmodule

// ==== hw/BlockFill.sv ====
`timescale 1ns/1ps

module BlockFill #(
    parameter int Depth = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       wrStrobe,
    input  ChecksumPkg::WordT          wrData,
    output logic                       fillReq,
    output logic [$clog2(Depth)-1:0]   fillAddr,
    output ChecksumPkg::WordT          fillData,
    output logic [$clog2(Depth+1)-1:0] count,
    output logic                       full
);
    localparam int AddrWidth  = $clog2(Depth);
    localparam int CountWidth = $clog2(Depth+1);

    // strobe turned into an actual write
    logic accept;

    // block holds Depth words at most
    assign full = (count == CountWidth'(Depth));

    // strobes while full are dropped
    // clear takes precedence over a same-cycle strobe
    assign accept = wrStrobe && !full && !clear;

    // request, address and data all in the strobe cycle
    assign fillReq  = accept;
    assign fillAddr = count[AddrWidth-1:0];
    assign fillData = wrData;

    // words land at 0, 1, 2, ... so count doubles as the write pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (accept) begin
            count <= count + 1'b1;
        end
    end
endmodule

// ==== hw/BlockScan.sv ====
`timescale 1ns/1ps

module BlockScan #(
    parameter int Depth = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [$clog2(Depth+1)-1:0] count,
    input  logic                       scanGrant,
    input  logic                       rdValid,
    input  ChecksumPkg::SumT           sumIn,
    output logic                       scanReq,
    output logic [$clog2(Depth)-1:0]   scanAddr,
    output logic                       sumClear,
    output logic                       sumEn,
    output logic                       busy,
    output logic                       done,
    output ChecksumPkg::SumT           checksum
);
    import ChecksumPkg::*;

    localparam int AddrWidth  = $clog2(Depth);
    localparam int CountWidth = $clog2(Depth+1);

    ScanStateT state;

    // block length frozen at start
    logic [CountWidth-1:0] len;
    // reads granted so far
    logic [CountWidth-1:0] issued;
    // words back from the RAM so far
    logic [CountWidth-1:0] returned;
    // second drain cycle
    logic drainLast;
    // final word arriving this cycle
    logic lastWord;

    assign lastWord = rdValid && (returned + 1'b1 == len);

    // keep asking until every word has been granted
    assign scanReq  = (state == ScanRead) && (issued != len);
    assign scanAddr = issued[AddrWidth-1:0];

    // core cleared on the same edge that accepts start
    assign sumClear = (state == ScanIdle) && start;
    assign sumEn    = (state == ScanRead) && rdValid;

    assign busy = (state != ScanIdle);
    assign done = (state == ScanDone);

    always_ff @(posedge clk) begin
        if (sumClear) begin
            len <= count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ScanIdle;
            issued    <= '0;
            returned  <= '0;
            drainLast <= 1'b0;
            checksum  <= '0;
        end else begin
            case (state)
                ScanIdle: begin
                    // start while busy never reaches here
                    if (start) begin
                        issued    <= '0;
                        returned  <= '0;
                        drainLast <= 1'b0;
                        // empty block goes straight to the drain
                        state <= (count == '0) ? ScanDrain : ScanRead;
                    end
                end
                ScanRead: begin
                    // address moves only on a granted read
                    if (scanReq && scanGrant) begin
                        issued <= issued + 1'b1;
                    end
                    if (rdValid) begin
                        returned <= returned + 1'b1;
                    end
                    if (lastWord) begin
                        state <= ScanDrain;
                    end
                end
                ScanDrain: begin
                    // two cycles for the lagging second sum
                    drainLast <= 1'b1;
                    if (drainLast) begin
                        checksum <= sumIn;
                        state    <= ScanDone;
                    end
                end
                ScanDone: begin
                    // done is high for this one cycle
                    state <= ScanIdle;
                end
                default: begin
                    state <= ScanIdle;
                end
            endcase
        end
    end
endmodule

// ==== hw/ChecksumTop.sv ====
`timescale 1ns/1ps

module ChecksumTop #(
    parameter int Depth = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wrStrobe,
    input  ChecksumPkg::WordT          wrData,
    input  logic                       clear,
    input  logic                       start,
    output logic                       full,
    output logic [$clog2(Depth+1)-1:0] count,
    output logic                       busy,
    output logic                       done,
    output ChecksumPkg::SumT           checksum
);
    import ChecksumPkg::*;

    localparam int AddrWidth = $clog2(Depth);

    // fill peer to arbiter
    logic                 fillReq;
    logic [AddrWidth-1:0] fillAddr;
    WordT                 fillData;

    // scan peer to arbiter
    logic                 scanReq;
    logic [AddrWidth-1:0] scanAddr;
    logic                 scanGrant;
    logic                 rdValid;

    // shared RAM port
    logic                 ramWe;
    logic [AddrWidth-1:0] ramAddr;
    WordT                 ramWrData;
    WordT                 ramRdData;

    // scanner to core
    logic                 sumClear;
    logic                 sumEn;
    SumT                  sumOut;

    BlockFill #(
        .Depth(Depth)
    ) fill (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .wrStrobe (wrStrobe),
        .wrData   (wrData),
        .fillReq  (fillReq),
        .fillAddr (fillAddr),
        .fillData (fillData),
        .count    (count),
        .full     (full)
    );

    BlockScan #(
        .Depth(Depth)
    ) scan (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .count     (count),
        .scanGrant (scanGrant),
        .rdValid   (rdValid),
        .sumIn     (sumOut),
        .scanReq   (scanReq),
        .scanAddr  (scanAddr),
        .sumClear  (sumClear),
        .sumEn     (sumEn),
        .busy      (busy),
        .done      (done),
        .checksum  (checksum)
    );

    RamArbiter #(
        .Depth(Depth)
    ) arb (
        .clk       (clk),
        .rst       (rst),
        .fillReq   (fillReq),
        .fillAddr  (fillAddr),
        .fillData  (fillData),
        .scanReq   (scanReq),
        .scanAddr  (scanAddr),
        .scanGrant (scanGrant),
        .rdValid   (rdValid),
        .ramWe     (ramWe),
        .ramAddr   (ramAddr),
        .ramWrData (ramWrData)
    );

    BlockRam #(
        .Depth(Depth)
    ) ram (
        .clk    (clk),
        .we     (ramWe),
        .addr   (ramAddr),
        .wrData (ramWrData),
        .rdData (ramRdData)
    );

    // returned words feed the core straight from the RAM
    FletcherChecksum core (
        .clk   (clk),
        .rst   (rst),
        .clear (sumClear),
        .en    (sumEn),
        .din   (ramRdData),
        .dout  (sumOut)
    );
endmodule

// ==== sim/ChecksumTop_properties.sv ====
`timescale 1ns/1ps

module ChecksumTop_properties (
    input logic clk,
    input logic rst,
    input logic ramWe,
    input logic rdValid,
    input logic done,
    input logic busy
);
    // a fill write cycle issues no scan read, so no word comes back after it
    assert property (@(posedge clk) disable iff (rst) ramWe |=> !rdValid)
        else $error("scan read issued in a fill write cycle");

    // single cycle done pulse
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

    // busy drops right after done
    assert property (@(posedge clk) disable iff (rst) done |=> !busy)
        else $error("busy still high after done");
endmodule

bind ChecksumTop ChecksumTop_properties props (
    .clk     (clk),
    .rst     (rst),
    .ramWe   (ramWe),
    .rdValid (rdValid),
    .done    (done),
    .busy    (busy)
);

// ==== sim/ChecksumTb.sv ====
`timescale 1ns/1ps

module ChecksumTb;
    import ChecksumPkg::*;

    localparam int Depth      = 256;
    localparam int CountWidth = $clog2(Depth+1);
    localparam int NumTests   = 9;
    // host writes pushed in while a contended scan runs
    localparam int ContWrites = 6;

    typedef logic [CountWidth-1:0] CountT;
    typedef enum {PatRamp, PatOnes, PatConst, PatRandom} PatternT;

    logic  clk = 1'b0;
    logic  rst;
    logic  wrStrobe;
    WordT  wrData;
    logic  clear;
    logic  start;
    logic  full;
    CountT count;
    logic  busy;
    logic  done;
    SumT   checksum;

    // test table, one entry per row
    string   tName    [NumTests];
    int      tWords   [NumTests];
    PatternT tPattern [NumTests];
    bit      tContend [NumTests];
    bit      tClear   [NumTests];
    int      tExtra   [NumTests];

    // words the DUT should hold, in address order
    WordT model [Depth];
    int   modelCount;
    int   errorCount;
    int   failedTests;
    bit   timedOut;

    ChecksumTop #(
        .Depth(Depth)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .wrStrobe (wrStrobe),
        .wrData   (wrData),
        .clear    (clear),
        .start    (start),
        .full     (full),
        .count    (count),
        .busy     (busy),
        .done     (done),
        .checksum (checksum)
    );

    always #5 clk = ~clk;

    task automatic addRow(input int idx, input string name, input int words,
                          input PatternT pat, input bit contend, input bit clr,
                          input int extra);
        tName[idx]    = name;
        tWords[idx]   = words;
        tPattern[idx] = pat;
        tContend[idx] = contend;
        tClear[idx]   = clr;
        tExtra[idx]   = extra;
    endtask

    task automatic loadTable();
        addRow(0, "ramp8", 8, PatRamp, 1'b0, 1'b1, 0);
        addRow(1, "const5", 5, PatConst, 1'b0, 1'b1, 0);
        // appends to the previous block
        addRow(2, "rampAppend", 32, PatRamp, 1'b0, 1'b0, 0);
        addRow(3, "ones64", 64, PatOnes, 1'b0, 1'b1, 0);
        addRow(4, "empty", 0, PatRamp, 1'b0, 1'b1, 0);
        addRow(5, "contend", 20, PatConst, 1'b1, 1'b1, 0);
        addRow(6, "rampContend", 40, PatRamp, 1'b1, 1'b0, 0);
        addRow(7, "full256", 256, PatRamp, 1'b0, 1'b1, 5);
        addRow(8, "random", 1 + ($urandom % 200), PatRandom, 1'b0, 1'b1, 0);
    endtask

    function automatic WordT patternWord(input PatternT pat, input int i);
        case (pat)
            PatRamp:  return WordT'(i * 7 + 1);
            PatOnes:  return 16'hffff;
            PatConst: return 16'h3c5a;
            default:  return WordT'($urandom);
        endcase
    endfunction

    // fletcher-32 over the first n model words
    function automatic SumT modelSum(input int n);
        int unsigned a;
        int unsigned b;
        a = 0;
        b = 0;
        for (int i = 0; i < n; i++) begin
            a = (a + model[i]) % FletcherMod;
            b = (b + a) % FletcherMod;
        end
        return {b[15:0], a[15:0]};
    endfunction

    task automatic checkSum(input string name, input SumT exp, input SumT act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input CountT exp, input CountT act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            errorCount++;
        end
    endtask

    // drives one strobe, edge left to the caller
    task automatic strobeWord(input WordT data);
        wrStrobe = 1'b1;
        wrData   = data;
        // strobes while full are dropped by the DUT
        if (modelCount < Depth) begin
            model[modelCount] = data;
            modelCount++;
        end
    endtask

    task automatic applyClear(input string name);
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear      = 1'b0;
        modelCount = 0;
        checkCount({name, ".clearCount"}, '0, count);
        checkFlag({name, ".clearFull"}, 1'b0, full);
    endtask

    task automatic fillBlock(input int words, input PatternT pat);
        for (int i = 0; i < words; i++) begin
            strobeWord(patternWord(pat, i));
            @(posedge clk);
            #1;
        end
        wrStrobe = 1'b0;
    endtask

    // start, optional contention, wait for done
    task automatic runScan(input string name, input bit contend);
        SumT expSum;
        int  expCycles;
        int  cycles;
        int  writesLeft;
        bit  seen;
        expSum     = modelSum(modelCount);
        writesLeft = contend ? ContWrites : 0;
        // cycles counted from the start drive edge, one extra per stalled read
        expCycles  = (modelCount == 0) ? 3 : modelCount + 4 + writesLeft;
        cycles     = 0;
        seen       = 1'b0;
        start      = 1'b1;
        while (!seen && cycles < 2 * Depth + 20) begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            if (cycles == 1) begin
                checkFlag({name, ".busy"}, 1'b1, busy);
            end
            if (done) begin
                seen     = 1'b1;
                wrStrobe = 1'b0;
            end else if (writesLeft > 0) begin
                strobeWord(WordT'(16'h5000 + writesLeft));
                writesLeft--;
            end else begin
                wrStrobe = 1'b0;
            end
        end
        if (!seen) begin
            $display("timeout: done never came in test %s after %0d cycles", name, cycles);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            checkCycles({name, ".latency"}, expCycles, cycles);
            checkSum({name, ".checksum"}, expSum, checksum);
            @(posedge clk);
            #1;
            checkFlag({name, ".donePulse"}, 1'b0, done);
            checkFlag({name, ".busyAfter"}, 1'b0, busy);
        end
    endtask

    initial begin
        int errorsBefore;
        rst         = 1'b1;
        wrStrobe    = 1'b0;
        wrData      = '0;
        clear       = 1'b0;
        start       = 1'b0;
        modelCount  = 0;
        errorCount  = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        void'($urandom(32'hfaf2_5900));
        loadTable();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle values straight out of reset
        checkCount("reset.count", '0, count);
        checkFlag("reset.full", 1'b0, full);
        checkFlag("reset.busy", 1'b0, busy);
        checkFlag("reset.done", 1'b0, done);
        checkSum("reset.checksum", '0, checksum);
        if (errorCount == 0) begin
            $display("PASS reset");
        end else begin
            $display("FAIL reset, %0d errors", errorCount);
            failedTests++;
        end

        for (int t = 0; t < NumTests; t++) begin
            errorsBefore = errorCount;
            if (tClear[t]) begin
                applyClear(tName[t]);
            end
            fillBlock(tWords[t] + tExtra[t], tPattern[t]);
            checkCount({tName[t], ".fillCount"}, CountT'(modelCount), count);
            checkFlag({tName[t], ".full"}, modelCount == Depth, full);
            runScan(tName[t], tContend[t]);
            // writes during the scan still land
            checkCount({tName[t], ".endCount"}, CountT'(modelCount), count);
            if (errorCount == errorsBefore) begin
                $display("PASS %s", tName[t]);
            end else begin
                $display("FAIL %s, %0d errors", tName[t], errorCount - errorsBefore);
                failedTests++;
            end
            if (timedOut) begin
                break;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", NumTests + 1, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

// ==== all.f ====
hw/ChecksumPkg.sv
hw/FletcherChecksum.sv
hw/BlockRam.sv
hw/RamArbiter.sv
hw/BlockFill.sv
hw/BlockScan.sv
hw/ChecksumTop.sv
sim/ChecksumTop_properties.sv
sim/ChecksumTb.sv
